// ==== hdl/div_pkg.sv ====
package div_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////////////

  // operand and result width
  localparam int unsigned DATA_WIDTH    = 32;
  // number of serial divider lanes
  localparam int unsigned NUM_LANES     = 4;
  // transaction id width
  localparam int unsigned ID_BITS       = 4;
  // depth of request and response fifo
  localparam int unsigned FIFO_DEPTH    = 4;
  // enough bits to name one lane
  localparam int unsigned LANE_IDX_BITS = 2;

  // leading-zero count width
  localparam int unsigned CNT_BITS      = $clog2(DATA_WIDTH);
  // shift of operand a, may reach DATA_WIDTH for a zero operand
  localparam int unsigned SHIFT_BITS    = $clog2(DATA_WIDTH + 1);
  // signed divisor shift, msb set when |b| > |a|
  localparam int unsigned DSHIFT_BITS   = SHIFT_BITS + 1;

  ////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////

  // bit 0 selects signed, bit 1 selects remainder
  typedef enum logic [1:0] {
    OP_UDIV = 2'd0,
    OP_DIV  = 2'd1,
    OP_UREM = 2'd2,
    OP_REM  = 2'd3
  } div_op_e;

  typedef struct packed {
    logic [ID_BITS-1:0]    id;
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    div_op_e               op;
  } div_req_t;

  typedef struct packed {
    logic [ID_BITS-1:0]    id;
    logic [DATA_WIDTH-1:0] res;
  } div_rsp_t;

endpackage

// ==== hdl/lzc.sv ====
`timescale 1ns/1ps

module lzc (
  input  logic [div_pkg::DATA_WIDTH-1:0] in_i,
  output logic [div_pkg::CNT_BITS-1:0]   cnt_o,
  output logic                           empty_o
);

  // scan from lsb upwards, the highest set bit is written last
  always_comb begin : p_count
    cnt_o = '0;
    for (int i = 0; i < div_pkg::DATA_WIDTH; i++) begin
      if (in_i[i]) begin
        cnt_o = div_pkg::CNT_BITS'(div_pkg::DATA_WIDTH - 1 - i);
      end
    end
  end

  // no one found, count is meaningless then
  assign empty_o = ~|in_i;

endmodule

// ==== hdl/serdiv.sv ====
`timescale 1ns/1ps

module serdiv (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  // request side
  input  logic               in_vld_i,
  output logic               in_rdy_o,
  input  div_pkg::div_req_t  req_i,
  // response side
  output logic               out_vld_o,
  input  logic               out_rdy_i,
  output div_pkg::div_rsp_t  rsp_o
);

  typedef enum logic [1:0] {IDLE, DIVIDE, FINISH} state_e;

  state_e state_d, state_q;

  logic [1:0] opcode;
  logic       op_a_sign, op_b_sign;
  logic       op_b_zero, op_b_neg_one;

  logic [div_pkg::DATA_WIDTH-1:0] op_a_q, op_b_q, res_q;
  logic [div_pkg::DATA_WIDTH-1:0] add_mux, add_tmp, add_out;
  logic [div_pkg::DATA_WIDTH-1:0] b_mux, out_mux;
  logic [div_pkg::ID_BITS-1:0]    id_q;

  // flags captured on load
  logic rem_sel_q, comp_inv_q, res_inv_q;
  logic op_b_zero_q, op_b_neg_one_q, div_res_zero_q;

  logic [div_pkg::DATA_WIDTH-1:0]  lzc_a_in, lzc_b_in, op_b_algn;
  logic [div_pkg::CNT_BITS-1:0]    lzc_a_cnt, lzc_b_cnt;
  logic                            lzc_a_empty, lzc_b_empty;
  logic [div_pkg::SHIFT_BITS-1:0]  shift_a;
  logic [div_pkg::DSHIFT_BITS-1:0] div_shift;

  logic [div_pkg::CNT_BITS-1:0] cnt_q;
  logic                         cnt_zero;

  logic load_en, a_reg_en, b_reg_en, res_reg_en;
  logic pm_sel, ab_comp, early_exit;

  //////////////////////////////////////////////////////////////////////
  // operand alignment
  //////////////////////////////////////////////////////////////////////

  assign opcode    = req_i.op;
  assign op_a_sign = req_i.op_a[div_pkg::DATA_WIDTH-1];
  assign op_b_sign = req_i.op_b[div_pkg::DATA_WIDTH-1];

  // an all-zero count input means b is 0 or, when signed, -1
  assign op_b_zero    = lzc_b_empty & ~op_b_sign;
  assign op_b_neg_one = lzc_b_empty &  op_b_sign;

  // negative operands counted on their one's complement
  assign lzc_a_in = (opcode[0] & op_a_sign) ?
                    {~req_i.op_a[div_pkg::DATA_WIDTH-2:0], 1'b1} : req_i.op_a;
  assign lzc_b_in = (opcode[0] & op_b_sign) ? ~req_i.op_b : req_i.op_b;

  lzc i_lzc_a (
    .in_i    (lzc_a_in),
    .cnt_o   (lzc_a_cnt),
    .empty_o (lzc_a_empty)
  );

  lzc i_lzc_b (
    .in_i    (lzc_b_in),
    .cnt_o   (lzc_b_cnt),
    .empty_o (lzc_b_empty)
  );

  // zero dividend counts as fully shifted
  assign shift_a   = lzc_a_empty ? div_pkg::SHIFT_BITS'(div_pkg::DATA_WIDTH) :
                                   div_pkg::SHIFT_BITS'(lzc_a_cnt);
  assign div_shift = div_pkg::DSHIFT_BITS'(lzc_b_cnt) - div_pkg::DSHIFT_BITS'(shift_a);

  // divisor moved up under the dividend's leading one
  assign op_b_algn = req_i.op_b << div_shift;

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  // load adds a for same signs, subtracts it otherwise
  assign pm_sel  = load_en & ~(opcode[0] & (op_a_sign ^ op_b_sign));
  assign add_mux = load_en ? req_i.op_a : op_b_q;

  // shift in the sign bit for a negative divisor
  assign b_mux   = load_en ? op_b_algn :
                   {comp_inv_q, op_b_q[div_pkg::DATA_WIDTH-1:1]};

  // compare partial remainder against divisor
  assign ab_comp = ((op_a_q == op_b_q) | ((op_a_q > op_b_q) ^ comp_inv_q)) & (|op_a_q);

  // restoring step
  assign add_tmp = load_en ? '0 : op_a_q;
  assign add_out = pm_sel ? add_tmp + add_mux : add_tmp - add_mux;

  // riscv special cases for x/0 and x/-1
  assign out_mux = rem_sel_q ? (op_b_neg_one_q ? '0 : op_a_q) :
                   (op_b_zero_q ? '1 : (op_b_neg_one_q ? op_a_q : res_q));

  // final sign correction
  assign rsp_o = '{id: id_q, res: (res_inv_q ? -out_mux : out_mux)};

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  assign cnt_zero   = (cnt_q == '0);
  assign early_exit = div_res_zero_q | op_b_zero_q | op_b_neg_one_q;

  always_comb begin : p_fsm
    state_d    = state_q;
    in_rdy_o   = 1'b0;
    out_vld_o  = 1'b0;
    load_en    = 1'b0;
    a_reg_en   = 1'b0;
    b_reg_en   = 1'b0;
    res_reg_en = 1'b0;

    unique case (state_q)
      IDLE: begin
        // ready only depends on state
        in_rdy_o = 1'b1;
        if (in_vld_i) begin
          load_en  = 1'b1;
          a_reg_en = 1'b1;
          b_reg_en = 1'b1;
          state_d  = DIVIDE;
        end
      end
      DIVIDE: begin
        if (early_exit) begin
          // result known without iterating
          out_vld_o = 1'b1;
          state_d   = out_rdy_i ? IDLE : FINISH;
        end else begin
          a_reg_en   = ab_comp;
          b_reg_en   = 1'b1;
          res_reg_en = 1'b1;
          if (cnt_zero) begin
            state_d = FINISH;
          end
        end
      end
      FINISH: begin
        // hold result under back-pressure
        out_vld_o = 1'b1;
        if (out_rdy_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // flush drops everything in flight
    if (flush_i) begin
      in_rdy_o  = 1'b0;
      out_vld_o = 1'b0;
      load_en   = 1'b0;
      a_reg_en  = 1'b0;
      b_reg_en  = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      state_q        <= IDLE;
      rem_sel_q      <= 1'b0;
      comp_inv_q     <= 1'b0;
      res_inv_q      <= 1'b0;
      op_b_zero_q    <= 1'b0;
      op_b_neg_one_q <= 1'b0;
      div_res_zero_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_en) begin
        rem_sel_q      <= opcode[1];
        comp_inv_q     <= opcode[0] & op_b_sign;
        res_inv_q      <= (~op_b_zero | opcode[1]) & opcode[0] &
                          (op_a_sign ^ op_b_sign ^ op_b_neg_one);
        op_b_zero_q    <= op_b_zero;
        op_b_neg_one_q <= op_b_neg_one;
        // negative shift means |b| > |a|
        div_res_zero_q <= div_shift[div_pkg::DSHIFT_BITS-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_data
    if (a_reg_en) begin
      op_a_q <= add_out;
    end
    if (b_reg_en) begin
      op_b_q <= b_mux;
    end
    // quotient bits shift in from the right
    if (load_en) begin
      res_q <= '0;
    end else if (res_reg_en) begin
      res_q <= {res_q[div_pkg::DATA_WIDTH-2:0], ab_comp};
    end
    // iteration count is the aligned shift
    if (load_en) begin
      cnt_q <= div_shift[div_pkg::CNT_BITS-1:0];
    end else if (!cnt_zero) begin
      cnt_q <= cnt_q - 1'b1;
    end
    if (load_en) begin
      id_q <= req_i.id;
    end
  end

endmodule

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  // write side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // read side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  payload_t mem_q [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] cnt_q;
  logic                       push, pop;

  // both sides closed during flush
  assign ready_o = (cnt_q != DEPTH) & ~flush_i;
  assign valid_o = (cnt_q != 0) & ~flush_i;
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptrs
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // fill level only moves on one-sided traffic
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin : p_mem
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== hdl/div_dispatch.sv ====
`timescale 1ns/1ps

module div_dispatch (
  // head of the request fifo
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  div_pkg::div_req_t              req_i,
  // lane side
  output logic [div_pkg::NUM_LANES-1:0] lane_vld_o,
  input  logic [div_pkg::NUM_LANES-1:0] lane_rdy_i,
  output div_pkg::div_req_t              lane_req_o
);

  // lowest idle lane wins, one-hot valid
  always_comb begin : p_pick
    logic found;
    found      = 1'b0;
    lane_vld_o = '0;
    for (int i = 0; i < div_pkg::NUM_LANES; i++) begin
      if (lane_rdy_i[i] && !found) begin
        lane_vld_o[i] = req_valid_i;
        found         = 1'b1;
      end
    end
  end

  // any idle lane takes the head this cycle
  assign req_ready_o = |lane_rdy_i;

  // payload shared by all lanes
  assign lane_req_o = req_i;

endmodule

// ==== hdl/div_collect.sv ====
`timescale 1ns/1ps

module div_collect (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  // lane side
  input  logic [div_pkg::NUM_LANES-1:0] lane_vld_i,
  output logic [div_pkg::NUM_LANES-1:0] lane_rdy_o,
  input  div_pkg::div_rsp_t              lane_rsp_i [div_pkg::NUM_LANES],
  // towards the response fifo
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output div_pkg::div_rsp_t              rsp_o
);

  logic [div_pkg::LANE_IDX_BITS-1:0] rr_q, gnt_idx;
  logic                              gnt_any;

  // first finished lane at or after the pointer
  always_comb begin : p_arb
    logic [div_pkg::LANE_IDX_BITS-1:0] idx;
    gnt_idx = rr_q;
    gnt_any = 1'b0;
    for (int i = 0; i < div_pkg::NUM_LANES; i++) begin
      idx = rr_q + div_pkg::LANE_IDX_BITS'(i);
      if (!gnt_any && lane_vld_i[idx]) begin
        gnt_idx = idx;
        gnt_any = 1'b1;
      end
    end
  end

  assign rsp_valid_o = gnt_any;
  assign rsp_o       = lane_rsp_i[gnt_idx];

  // only the granted lane sees ready
  always_comb begin : p_rdy
    lane_rdy_o          = '0;
    lane_rdy_o[gnt_idx] = gnt_any & rsp_ready_i;
  end

  // pointer skips past the lane just served
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (flush_i) begin
      rr_q <= '0;
    end else if (rsp_valid_o && rsp_ready_i) begin
      rr_q <= gnt_idx + 1'b1;
    end
  end

endmodule

// ==== hdl/div_unit_top.sv ====
`timescale 1ns/1ps

module div_unit_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  // requests
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  div_pkg::div_req_t req_i,
  // responses, possibly out of order
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output div_pkg::div_rsp_t rsp_o
);

  // request fifo head
  logic              head_valid, head_ready;
  div_pkg::div_req_t head_req;

  // lane handshakes
  logic [div_pkg::NUM_LANES-1:0] lane_in_vld, lane_in_rdy;
  logic [div_pkg::NUM_LANES-1:0] lane_out_vld, lane_out_rdy;
  div_pkg::div_req_t             lane_req;
  div_pkg::div_rsp_t             lane_rsp [div_pkg::NUM_LANES];

  // collector to response fifo
  logic              col_valid, col_ready;
  div_pkg::div_rsp_t col_rsp;

  ////////////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////////////

  stream_fifo #(
    .payload_t (div_pkg::div_req_t),
    .DEPTH     (div_pkg::FIFO_DEPTH)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (req_i),
    .valid_o (head_valid),
    .ready_i (head_ready),
    .data_o  (head_req)
  );

  div_dispatch i_dispatch (
    .req_valid_i (head_valid),
    .req_ready_o (head_ready),
    .req_i       (head_req),
    .lane_vld_o  (lane_in_vld),
    .lane_rdy_i  (lane_in_rdy),
    .lane_req_o  (lane_req)
  );

  // identical serial lanes
  for (genvar g = 0; g < div_pkg::NUM_LANES; g++) begin : gen_lane
    serdiv i_serdiv (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .flush_i   (flush_i),
      .in_vld_i  (lane_in_vld[g]),
      .in_rdy_o  (lane_in_rdy[g]),
      .req_i     (lane_req),
      .out_vld_o (lane_out_vld[g]),
      .out_rdy_i (lane_out_rdy[g]),
      .rsp_o     (lane_rsp[g])
    );
  end

  ////////////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////////////

  div_collect i_collect (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .lane_vld_i  (lane_out_vld),
    .lane_rdy_o  (lane_out_rdy),
    .lane_rsp_i  (lane_rsp),
    .rsp_valid_o (col_valid),
    .rsp_ready_i (col_ready),
    .rsp_o       (col_rsp)
  );

  stream_fifo #(
    .payload_t (div_pkg::div_rsp_t),
    .DEPTH     (div_pkg::FIFO_DEPTH)
  ) i_rsp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .valid_i (col_valid),
    .ready_o (col_ready),
    .data_i  (col_rsp),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i),
    .data_o  (rsp_o)
  );

endmodule

// ==== verif/div_tb.sv ====
`timescale 1ns/1ps

module div_tb;

  // run length and test phases, counted in generated requests
  localparam int NUM_REQS       = 300;
  localparam int DIR_AT         = 80;
  localparam int DIR_NUM        = 14;
  localparam int BP_AT          = 150;
  localparam int BP_CYCLES      = 60;
  localparam int FLUSH_AT       = 230;
  localparam int NUM_IDS        = 2 ** div_pkg::ID_BITS;
  // worst case lane latency plus queueing, per request
  localparam int TIMEOUT_CYCLES = NUM_REQS * (div_pkg::DATA_WIDTH + 8) + 1000;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              flush_i;
  logic              req_valid_i;
  logic              req_ready_o;
  div_pkg::div_req_t req_i;
  logic              rsp_valid_o;
  logic              rsp_ready_i;
  div_pkg::div_rsp_t rsp_o;

  // scoreboard, indexed by transaction id
  div_pkg::div_req_t issued_tab [NUM_IDS];
  div_pkg::div_rsp_t expect_tab [NUM_IDS];
  int                seq_tab    [NUM_IDS];
  logic              pending    [NUM_IDS];

  integer                      seed;
  logic [div_pkg::ID_BITS-1:0] next_id;
  int gen_cnt, accepted_cnt, retired_cnt, flushed_cnt, in_flight;
  int ooo_cnt, newest_retired, bp_left, cycle_cnt;
  logic bp_done, saw_stall, flush_done, finished, accepted;

  div_unit_top UUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // reporting and checks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_rsp(input div_pkg::div_rsp_t got, input div_pkg::div_rsp_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH at %0t ns: id %0d result %h, expected id %0d result %h",
                         $time, got.id, got.res, exp.id, exp.res));
    end
  endtask

  // id must be outstanding, otherwise it is a stray or a duplicate
  task automatic check_issued(input div_pkg::div_req_t req,
                              input logic [div_pkg::ID_BITS-1:0] id);
    if (pending[id] !== 1'b1) begin
      // an id never written still holds x in its table entry
      if ($isunknown(req)) begin
        fail_now($sformatf("response for id %0d at %0t ns, but that id was never issued",
                           id, $time));
      end else begin
        fail_now($sformatf("response for id %0d at %0t ns, but that id is not outstanding",
                           id, $time));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model with riscv rules
  //////////////////////////////////////////////////////////////////////

  function automatic logic [div_pkg::DATA_WIDTH-1:0] model_result(
    input div_pkg::div_req_t req
  );
    logic signed [div_pkg::DATA_WIDTH-1:0] sa, sb;
    logic        [div_pkg::DATA_WIDTH-1:0] min_val, res;
    logic                                  zero_div, overflow;
    sa       = req.op_a;
    sb       = req.op_b;
    min_val  = {1'b1, {(div_pkg::DATA_WIDTH-1){1'b0}}};
    zero_div = (req.op_b == '0);
    // most negative over minus one
    overflow = (req.op_a == min_val) && (req.op_b == '1);
    case (req.op)
      div_pkg::OP_UDIV: res = zero_div ? '1 : req.op_a / req.op_b;
      div_pkg::OP_UREM: res = zero_div ? req.op_a : req.op_a % req.op_b;
      div_pkg::OP_DIV: begin
        // x/0 and min/-1 first, signed quotient otherwise
        if (zero_div) res = '1;
        else if (overflow) res = min_val;
        else res = sa / sb;
      end
      default: begin
        if (zero_div) res = req.op_a;
        else if (overflow) res = '0;
        else res = sa % sb;
      end
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // corner cases: x/0, min/-1, divisor above dividend
  function automatic div_pkg::div_req_t directed_req(input int k,
                                                     input logic [div_pkg::ID_BITS-1:0] id);
    div_pkg::div_req_t req;
    case (k)
      0:  req = '{id, 32'd1234, 32'd0, div_pkg::OP_UDIV};
      1:  req = '{id, 32'd1234, 32'd0, div_pkg::OP_UREM};
      2:  req = '{id, 32'hffff_ffb3, 32'd0, div_pkg::OP_DIV};
      3:  req = '{id, 32'hffff_ffb3, 32'd0, div_pkg::OP_REM};
      4:  req = '{id, 32'h8000_0000, 32'hffff_ffff, div_pkg::OP_DIV};
      5:  req = '{id, 32'h8000_0000, 32'hffff_ffff, div_pkg::OP_REM};
      6:  req = '{id, 32'd5, 32'd100, div_pkg::OP_UDIV};
      7:  req = '{id, 32'd5, 32'd100, div_pkg::OP_UREM};
      8:  req = '{id, 32'hffff_fffd, 32'd7, div_pkg::OP_DIV};
      9:  req = '{id, 32'hffff_fffd, 32'd7, div_pkg::OP_REM};
      10: req = '{id, 32'd9, 32'hffff_ffec, div_pkg::OP_REM};
      11: req = '{id, 32'd100, 32'hffff_ffff, div_pkg::OP_DIV};
      // longest iteration
      12: req = '{id, 32'hffff_ffff, 32'd1, div_pkg::OP_UDIV};
      default: req = '{id, 32'd0, 32'd0, div_pkg::OP_UREM};
    endcase
    return req;
  endfunction

  task automatic random_req(input logic [div_pkg::ID_BITS-1:0] id,
                            output div_pkg::div_req_t req);
    logic [div_pkg::DATA_WIDTH-1:0] a, b;
    logic [31:0]                    r;
    a = $random(seed);
    b = $random(seed);
    r = $random(seed);
    // shape operands so iteration counts spread
    case (r[4:2])
      3'd0: b = b >> r[12:8];
      3'd1: a = a >> r[12:8];
      3'd2: b = b & 32'h0000_00ff;
      3'd3: b = {{(div_pkg::DATA_WIDTH-4){b[div_pkg::DATA_WIDTH-1]}}, b[3:0]};
      default: ;
    endcase
    req.id   = id;
    req.op_a = a;
    req.op_b = b;
    req.op   = div_pkg::div_op_e'(r[1:0]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // scoreboard updates
  //////////////////////////////////////////////////////////////////////

  task automatic accept_req(input div_pkg::div_req_t req);
    issued_tab[req.id] = req;
    expect_tab[req.id] = '{id: req.id, res: model_result(req)};
    seq_tab[req.id]    = accepted_cnt;
    pending[req.id]    = 1'b1;
    accepted_cnt++;
    in_flight++;
  endtask

  task automatic retire_rsp(input div_pkg::div_rsp_t rsp);
    check_issued(issued_tab[rsp.id], rsp.id);
    compare_rsp(rsp, expect_tab[rsp.id]);
    // older than something already retired
    if (seq_tab[rsp.id] < newest_retired) begin
      ooo_cnt++;
    end else begin
      newest_retired = seq_tab[rsp.id];
    end
    pending[rsp.id] = 1'b0;
    retired_cnt++;
    in_flight--;
  endtask

  // values seen at the edge are the ones held over the last cycle
  task automatic observe_edge(output logic acc);
    acc = 1'b0;
    if (flush_i) begin
      if (rsp_valid_o || req_ready_o) begin
        fail_now("valid or ready output was high during the flush cycle");
      end
      // everything in flight is dropped
      for (int i = 0; i < NUM_IDS; i++) begin
        if (pending[i]) begin
          pending[i] = 1'b0;
          flushed_cnt++;
        end
      end
      in_flight = 0;
    end else begin
      if (rsp_valid_o && rsp_ready_i) begin
        retire_rsp(rsp_o);
      end
      if (req_valid_i && req_ready_o) begin
        accept_req(req_i);
        acc = 1'b1;
      end
      if (bp_left > 0 && !req_ready_o) begin
        saw_stall = 1'b1;
      end
    end
  endtask

  task automatic drive_inputs(input logic acc);
    div_pkg::div_req_t req;
    flush_i <= 1'b0;
    if (!bp_done && gen_cnt >= BP_AT) begin
      bp_left = BP_CYCLES;
      bp_done = 1'b1;
    end
    // response side, long stall once, random gaps otherwise
    if (bp_left > 0) begin
      rsp_ready_i <= 1'b0;
      bp_left = bp_left - 1;
      if (bp_left == 0 && !saw_stall) begin
        fail_now("req_ready_o never dropped while responses were held back");
      end
    end else begin
      rsp_ready_i <= ($unsigned($random(seed)) % 3) != 0;
    end
    // request side
    if (!flush_done && gen_cnt >= FLUSH_AT && in_flight >= 4) begin
      flush_i     <= 1'b1;
      req_valid_i <= 1'b0;
      flush_done = 1'b1;
    end else if (req_valid_i && !acc) begin
      // payload stays put until taken
    end else if (gen_cnt < NUM_REQS && !pending[next_id]) begin
      if (gen_cnt >= DIR_AT && gen_cnt < DIR_AT + DIR_NUM) begin
        req = directed_req(gen_cnt - DIR_AT, next_id);
      end else begin
        random_req(next_id, req);
      end
      req_i       <= req;
      req_valid_i <= 1'b1;
      next_id++;
      gen_cnt++;
    end else begin
      req_valid_i <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : p_main
    seed           = 57;
    next_id        = '0;
    gen_cnt        = 0;
    accepted_cnt   = 0;
    retired_cnt    = 0;
    flushed_cnt    = 0;
    in_flight      = 0;
    ooo_cnt        = 0;
    newest_retired = -1;
    bp_left        = 0;
    bp_done        = 1'b0;
    saw_stall      = 1'b0;
    flush_done     = 1'b0;
    finished       = 1'b0;
    for (int i = 0; i < NUM_IDS; i++) begin
      pending[i] = 1'b0;
    end
    rst_ni      <= 1'b0;
    flush_i     <= 1'b0;
    req_valid_i <= 1'b0;
    req_i       <= '0;
    rsp_ready_i <= 1'b0;

    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (rsp_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
      fail_now("after reset rsp_valid_o is not low or req_ready_o is not high");
    end

    while (!finished) begin
      @(posedge clk_i);
      observe_edge(accepted);
      if (gen_cnt == NUM_REQS && !req_valid_i && in_flight == 0) begin
        finished = 1'b1;
      end else begin
        drive_inputs(accepted);
      end
    end

    if (flushed_cnt > 0 && ooo_cnt > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_now($sformatf("end of run: %0d accepted, %0d retired, %0d flushed, %0d out of order",
                         accepted_cnt, retired_cnt, flushed_cnt, ooo_cnt));
    end
  end

  // hard limit on run length
  always @(posedge clk_i) begin : p_timeout
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_now($sformatf("timeout after %0d cycles with %0d requests in flight",
                         cycle_cnt, in_flight));
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  initial begin : p_cycle_init
    cycle_cnt = 0;
  end

endmodule

// ==== build.f ====
hdl/div_pkg.sv
hdl/lzc.sv
hdl/serdiv.sv
hdl/stream_fifo.sv
hdl/div_dispatch.sv
hdl/div_collect.sv
hdl/div_unit_top.sv
verif/div_tb.sv
